/* hdl/core_ctrl.sv */
module core_ctrl #(
    parameter core_pkg::word_t RESET_VECTOR = '0
) (
    input  logic               i_reset_n,   // Clock
    input  logic               i_reset,
    dec_if.ctl                 dec,
    input  core_pkg::word_t    i_rhs,
    input  core_pkg::word_t    i_z_val,
    input  core_pkg::word_t    i_mem_rdata,
    output core_pkg::word_t    o_pc,
    output logic               o_we,
    output core_pkg::reg_idx_t o_w_idx,
    output core_pkg::word_t    o_w_data,
    output logic               o_mem_en,
    output logic               o_mem_we,
    output core_pkg::word_t    o_mem_addr,
    output core_pkg::word_t    o_mem_wdata,
    output logic               o_halt
);
    import core_pkg::*;

    word_t pc_q;
    logic  halt_q;
    logic  active;
    logic  writes_z;
    logic  jump;
    word_t wb_data;
    word_t pc_next;

    assign active = !halt_q && !i_reset;

    // deref 00 and 01 write Z, 10 and 11 store
    assign writes_z = dec.exec_ok && !dec.deref[1];
    assign wb_data  = dec.deref[0] ? i_mem_rdata : i_rhs;   // Load or plain result
    assign jump     = writes_z && (dec.z == PC_IDX);
    assign pc_next  = jump ? wb_data : pc_q + 32'd1;

    always_ff @(posedge i_reset_n) begin
        if (i_reset) begin
            pc_q   <= RESET_VECTOR;
            halt_q <= 1'b0;
        end else if (!halt_q) begin
            if (dec.illegal) begin
                halt_q <= 1'b1;   // PC stays on the illegal word
            end else begin
                pc_q <= pc_next;
            end
        end
    end

    assign o_pc   = pc_q;
    assign o_halt = halt_q;

    // Register write port
    assign o_we     = active && writes_z;
    assign o_w_idx  = dec.z;
    assign o_w_data = wb_data;

    // 01 loads from [rhs], 10 stores rhs to [Z], 11 stores Z to [rhs]
    assign o_mem_en    = active && (dec.deref != 2'b00);
    assign o_mem_we    = o_mem_en && dec.deref[1];
    assign o_mem_addr  = dec.deref[0] ? i_rhs : i_z_val;
    assign o_mem_wdata = dec.deref[0] ? i_z_val : i_rhs;

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 4;
    localparam int IMM_W     = 12;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // ALU operations, encoded as in the op field
    typedef enum logic [3:0] {
        OP_OR   = 4'b0000,
        OP_AND  = 4'b0001,
        OP_ADD  = 4'b0010,
        OP_MUL  = 4'b0011,
        OP_RSVD = 4'b0100,  // Yields zero
        OP_SHL  = 4'b0101,
        OP_LE   = 4'b0110,
        OP_EQ   = 4'b0111,
        OP_NOR  = 4'b1000,
        OP_NAND = 4'b1001,
        OP_XOR  = 4'b1010,
        OP_SUB  = 4'b1011,
        OP_XNOR = 4'b1100,
        OP_SHR  = 4'b1101,
        OP_GT   = 4'b1110,
        OP_NE   = 4'b1111
    } alu_op_e;

    // Operand view of an executing instruction
    typedef struct packed {
        logic             rsvd;   // Always 0 for classes 0xxx
        logic             typ;    // Swaps the roles of Y and the immediate
        logic [1:0]       deref;
        reg_idx_t         z;
        reg_idx_t         x;
        reg_idx_t         y;
        alu_op_e          op;
        logic [IMM_W-1:0] imm;
    } insn_fields_t;

    // Class view, top nibble only
    typedef struct packed {
        logic [3:0]  nibble;
        logic [27:0] payload;
    } insn_class_t;

    typedef union packed {
        insn_fields_t fields;
        insn_class_t  cls;
    } insn_u;

    localparam reg_idx_t PC_IDX = 4'd15;

endpackage

/* hdl/core_top.sv */
module core_top #(
    parameter core_pkg::word_t RESET_VECTOR = '0
) (
    input  logic            i_reset_n,   // Clock
    input  logic            i_reset,
    input  core_pkg::word_t i_insn_data,
    input  core_pkg::word_t i_mem_rdata,
    output core_pkg::word_t o_insn_addr,
    output logic            o_mem_en,
    output logic            o_mem_we,
    output core_pkg::word_t o_mem_addr,
    output core_pkg::word_t o_mem_wdata,
    output logic            o_halt
);
    import core_pkg::*;

    dec_if dec_bus ();

    word_t    x_val;
    word_t    y_val;
    word_t    z_val;
    word_t    rhs;
    logic     we;
    reg_idx_t w_idx;
    word_t    w_data;

    insn_decode u_decode (
        .i_insn (i_insn_data),
        .dec    (dec_bus)
    );

    // Register reads run alongside decode
    reg_file #(
        .NUM_REGS (PC_IDX + 1)
    ) u_regs (
        .i_reset_n (i_reset_n),
        .i_reset   (i_reset),
        .i_x_idx   (dec_bus.x),
        .i_y_idx   (dec_bus.y),
        .i_z_idx   (dec_bus.z),
        .i_pc      (o_insn_addr),
        .i_we      (we),
        .i_w_idx   (w_idx),
        .i_w_data  (w_data),
        .o_x_val   (x_val),
        .o_y_val   (y_val),
        .o_z_val   (z_val)
    );

    exec_unit u_exec (
        .dec     (dec_bus),
        .i_x_val (x_val),
        .i_y_val (y_val),
        .o_rhs   (rhs)
    );

    core_ctrl #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_ctrl (
        .i_reset_n   (i_reset_n),
        .i_reset     (i_reset),
        .dec         (dec_bus),
        .i_rhs       (rhs),
        .i_z_val     (z_val),
        .i_mem_rdata (i_mem_rdata),
        .o_pc        (o_insn_addr),   // Fetch address is the PC
        .o_we        (we),
        .o_w_idx     (w_idx),
        .o_w_data    (w_data),
        .o_mem_en    (o_mem_en),
        .o_mem_we    (o_mem_we),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_halt      (o_halt)
    );

endmodule

/* hdl/dec_if.sv */
interface dec_if;
    import core_pkg::*;

    reg_idx_t         z;
    reg_idx_t         x;
    reg_idx_t         y;
    alu_op_e          op;
    logic [IMM_W-1:0] imm;
    logic             typ;
    logic [1:0]       deref;
    logic             exec_ok;   // Class 0xxx
    logic             illegal;   // Class 1111

    modport src (
        output z, x, y, op, imm, typ, deref, exec_ok, illegal
    );

    modport ex (
        input x, y, op, imm, typ
    );

    modport ctl (
        input z, deref, exec_ok, illegal
    );

endinterface

/* hdl/exec_unit.sv */
module exec_unit (
    dec_if.ex               dec,
    input  core_pkg::word_t i_x_val,
    input  core_pkg::word_t i_y_val,
    output core_pkg::word_t o_rhs
);
    import core_pkg::*;

    word_t    imm_sx;
    word_t    opnd_o;   // Second ALU operand
    word_t    opnd_a;   // Addend
    word_t    alu_res;
    logic [4:0] shamt;

    assign imm_sx = {{(WORD_W - IMM_W){dec.imm[IMM_W-1]}}, dec.imm};

    // Type 0 is X op Y + I, type 1 is X op I + Y
    assign opnd_o = dec.typ ? imm_sx : i_y_val;
    assign opnd_a = dec.typ ? i_y_val : imm_sx;
    assign shamt  = opnd_o[4:0];

    always_comb begin
        case (dec.op)
            OP_OR:   alu_res = i_x_val | opnd_o;
            OP_AND:  alu_res = i_x_val & opnd_o;
            OP_ADD:  alu_res = i_x_val + opnd_o;
            OP_MUL:  alu_res = i_x_val * opnd_o;   // Low word only
            OP_SHL:  alu_res = i_x_val << shamt;
            OP_LE:   alu_res = word_t'($signed(i_x_val) <= $signed(opnd_o));
            OP_EQ:   alu_res = word_t'(i_x_val == opnd_o);
            OP_NOR:  alu_res = ~(i_x_val | opnd_o);
            OP_NAND: alu_res = ~(i_x_val & opnd_o);
            OP_XOR:  alu_res = i_x_val ^ opnd_o;
            OP_SUB:  alu_res = i_x_val - opnd_o;
            OP_XNOR: alu_res = ~(i_x_val ^ opnd_o);
            OP_SHR:  alu_res = i_x_val >> shamt;   // Logical
            OP_GT:   alu_res = word_t'($signed(i_x_val) > $signed(opnd_o));
            OP_NE:   alu_res = word_t'(i_x_val != opnd_o);
            default: alu_res = '0;   // Reserved, result is just A
        endcase
    end

    assign o_rhs = alu_res + opnd_a;

endmodule

/* hdl/insn_decode.sv */
module insn_decode (
    input  core_pkg::insn_u i_insn,
    dec_if.src              dec
);
    import core_pkg::*;

    always_comb begin
        // Non-executing classes leave everything zero, so no write and no strobe
        dec.z       = '0;
        dec.x       = '0;
        dec.y       = '0;
        dec.op      = OP_OR;
        dec.imm     = '0;
        dec.typ     = 1'b0;
        dec.deref   = 2'b00;
        dec.exec_ok = 1'b0;
        dec.illegal = 1'b0;

        if (!i_insn.cls.nibble[3]) begin
            dec.exec_ok = 1'b1;
            dec.z       = i_insn.fields.z;
            dec.x       = i_insn.fields.x;
            dec.y       = i_insn.fields.y;
            dec.op      = i_insn.fields.op;
            dec.imm     = i_insn.fields.imm;
            dec.typ     = i_insn.fields.typ;
            dec.deref   = i_insn.fields.deref;
        end else if (i_insn.cls.nibble == 4'b1111) begin
            dec.illegal = 1'b1;   // Halts the core
        end
        // Classes 1000 to 1110 fall through as no-ops
    end

endmodule

/* hdl/reg_file.sv */
module reg_file #(
    parameter int NUM_REGS = 16
) (
    input  logic               i_reset_n,   // Clock
    input  logic               i_reset,
    input  core_pkg::reg_idx_t i_x_idx,
    input  core_pkg::reg_idx_t i_y_idx,
    input  core_pkg::reg_idx_t i_z_idx,
    input  core_pkg::word_t    i_pc,
    input  logic               i_we,
    input  core_pkg::reg_idx_t i_w_idx,
    input  core_pkg::word_t    i_w_data,
    output core_pkg::word_t    o_x_val,
    output core_pkg::word_t    o_y_val,
    output core_pkg::word_t    o_z_val
);
    import core_pkg::*;

    // Only 1 to 14 are stored; 0 is constant and 15 is the PC
    word_t regs [1:NUM_REGS-2];

    function automatic word_t read_port(reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (idx == PC_IDX) begin
            val = i_pc;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge i_reset_n) begin
        if (i_reset) begin
            for (int i = 1; i <= NUM_REGS - 2; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_w_idx != '0) && (i_w_idx != PC_IDX)) begin
            regs[i_w_idx] <= i_w_data;   // PC writes are taken by core_ctrl
        end
    end

    always_comb begin
        o_x_val = read_port(i_x_idx);
        o_y_val = read_port(i_y_idx);
        o_z_val = read_port(i_z_idx);
    end

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module core_tb -f tb.f -o core_sim > build.log 2>&1 \
    && ./obj_dir/core_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

/* tb.f */
+incdir+verification
hdl/core_pkg.sv
hdl/dec_if.sv
hdl/insn_decode.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/core_ctrl.sv
hdl/core_top.sv
verification/core_tb.sv

/* verification/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

word_t m_regs [16];
word_t m_mem [DMEM_SIZE];
word_t m_pc;
logic  m_halted;
logic  m_en;
logic  m_we;
word_t m_addr;
word_t m_wdata;

// Contents of data words outside the array, distinct per address
function automatic word_t fill_word(word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0000;
endfunction

function automatic word_t fetch_word(word_t addr);
    return (addr < IMEM_SIZE) ? imem[addr[7:0]] : ILLEGAL;
endfunction

function automatic word_t make_insn(logic [1:0] deref, logic typ, reg_idx_t z, reg_idx_t x,
                                    reg_idx_t y, logic [3:0] op, logic [11:0] imm);
    insn_u w;
    w.fields = '{rsvd: 1'b0, typ: typ, deref: deref, z: z, x: x, y: y,
                 op: alu_op_e'(op), imm: imm};
    return w;
endfunction

function automatic word_t alu_ref(logic [3:0] op, word_t x, word_t o);
    case (op)
        4'h0: return x | o;
        4'h1: return x & o;
        4'h2: return x + o;
        4'h3: return x * o;
        4'h5: return x << o[4:0];
        4'h6: return {31'b0, $signed(x) <= $signed(o)};
        4'h7: return {31'b0, x == o};
        4'h8: return ~(x | o);
        4'h9: return ~(x & o);
        4'ha: return x ^ o;
        4'hb: return x - o;
        4'hc: return ~(x ^ o);
        4'hd: return x >> o[4:0];
        4'he: return {31'b0, $signed(x) > $signed(o)};
        4'hf: return {31'b0, x != o};
        default: return '0;   // Reserved op
    endcase
endfunction

function automatic word_t read_reg(reg_idx_t idx);
    return (idx == 4'd0) ? '0 : (idx == 4'd15) ? m_pc : m_regs[idx];
endfunction

// One instruction of the shadow machine
task automatic model_step(insn_u w);
    word_t imm;
    word_t o;
    word_t a;
    word_t rhs;
    word_t res;
    word_t next_pc;
    m_en = 1'b0;
    m_we = 1'b0;
    m_addr = '0;
    m_wdata = '0;
    next_pc = m_pc + 32'd1;
    if (w.cls.nibble == 4'hf) begin
        m_halted = 1'b1;
        next_pc = m_pc;   // Stays on the illegal word
    end else if (!w.cls.nibble[3]) begin
        imm = {{20{w.fields.imm[11]}}, w.fields.imm};
        o = w.fields.typ ? imm : read_reg(w.fields.y);
        a = w.fields.typ ? read_reg(w.fields.y) : imm;
        rhs = alu_ref(w.fields.op, read_reg(w.fields.x), o) + a;
        res = rhs;
        m_en = (w.fields.deref != 2'b00);
        m_we = w.fields.deref[1];
        m_addr = w.fields.deref[0] ? rhs : read_reg(w.fields.z);
        m_wdata = w.fields.deref[0] ? read_reg(w.fields.z) : rhs;
        if (w.fields.deref == 2'b01) begin
            res = (rhs < DMEM_SIZE) ? m_mem[rhs[7:0]] : fill_word(rhs);
        end
        if (m_we && m_addr < DMEM_SIZE) begin
            m_mem[m_addr[7:0]] = m_wdata;
        end
        if (!w.fields.deref[1] && w.fields.z == 4'd15) begin
            next_pc = res;   // Jump
        end else if (!w.fields.deref[1] && w.fields.z != 4'd0) begin
            m_regs[w.fields.z] = res;
        end
    end
    m_pc = next_pc;
endtask

`endif

/* verification/core_tb.sv */
module core_tb;
    import core_pkg::*;

    localparam int    IMEM_SIZE = 256;
    localparam int    DMEM_SIZE = 256;
    localparam word_t ILLEGAL   = 32'hf000_0000;

    logic  reset_n;   // Clock
    logic  reset;
    word_t insn_data;
    word_t mem_rdata;
    word_t insn_addr;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_en;
    logic  mem_we;
    logic  halt;
    word_t imem [IMEM_SIZE];
    word_t dmem [DMEM_SIZE];
    int    prog_len;
    int    errors;
    int    n_pass;
    int    n_fail;

    `include "core_model.svh"

    core_top #(
        .RESET_VECTOR (32'd0)
    ) dut0 (
        .i_reset_n   (reset_n),
        .i_reset     (reset),
        .i_insn_data (insn_data),
        .i_mem_rdata (mem_rdata),
        .o_insn_addr (insn_addr),
        .o_mem_en    (mem_en),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_halt      (halt)
    );

    initial begin
        reset_n = 1'b0;
        forever #50 reset_n = ~reset_n;
    end

    // Both memories answer in the same cycle
    always_comb begin
        insn_data = (insn_addr < IMEM_SIZE) ? imem[insn_addr[7:0]] : ILLEGAL;
        mem_rdata = (mem_addr < DMEM_SIZE) ? dmem[mem_addr[7:0]] : fill_word(mem_addr);
    end

    task automatic check(logic ok, string msg);
        assert (ok) else begin
            $display("error: time %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic put(word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    function automatic word_t rand_insn(logic [1:0] deref, reg_idx_t z);
        return make_insn(deref, 1'($urandom), z, 4'($urandom), 4'($urandom),
                         4'($urandom), 12'($urandom));
    endfunction

    task automatic build_program(int kind);
        reg_idx_t z;
        logic [11:0] a;
        put({4'(8 + $urandom_range(6, 0)), 28'($urandom)});   // No-op class first
        for (int i = 1; i < 15; i++) begin
            put(make_insn(2'b00, 1'b0, 4'(i), 4'd0, 4'd0, OP_OR, 12'($urandom)));
        end
        for (int i = 0; i < 30; i++) begin
            z = 4'($urandom_range(14, 1));
            a = 12'($urandom_range(255, 0));   // Inside the data array
            case (kind)
                2: begin
                    put(rand_insn(2'b00, z));
                    put(make_insn(2'b11, 1'b0, z, 4'd0, 4'd0, OP_OR, a));
                end
                3: begin
                    put(make_insn(2'b01, 1'b0, z, 4'd0, 4'd0, OP_OR, a));
                    put(make_insn(2'b11, 1'b0, z, 4'd0, 4'd0, OP_OR,
                                  12'($urandom_range(255, 0))));
                    put(make_insn(2'b00, 1'b0, z, 4'd0, 4'd0, OP_OR, a));
                    put(rand_insn(2'b10, z));   // mem[Z] gets rhs
                end
                4: begin
                    case ($urandom_range(3, 0))
                        0: put(rand_insn(2'b00, z));
                        1: put({4'(8 + $urandom_range(6, 0)), 28'($urandom)});
                        2: put(make_insn(2'b00, 1'b0, 4'd15, 4'd0, 4'd0, OP_OR,
                                         12'(prog_len + 1 + $urandom_range(3, 0))));
                        default: put(make_insn(2'b00, 1'b0, 4'd15, 4'd15, 4'd0, OP_ADD,
                                               12'($urandom_range(3, 1))));
                    endcase
                end
                5: begin
                    put(rand_insn(2'b00, 4'd0));
                    put(make_insn(2'b01, 1'b0, 4'd0, 4'd0, 4'd0, OP_OR, a));
                    put(make_insn(2'b11, 1'b0, 4'd0, 4'd0, 4'd0, OP_OR, a));
                end
                6: put(rand_insn(2'b00, z));
                default: ;
            endcase
        end
        put(ILLEGAL);
    endtask

    task automatic run_test(string name, int kind);
        int cycles;
        word_t first_word;
        errors = 0;
        prog_len = 0;
        for (int i = 0; i < IMEM_SIZE; i++) begin
            imem[i] = ILLEGAL;
        end
        for (int i = 0; i < DMEM_SIZE; i++) begin
            dmem[i] = fill_word(32'(i));
            m_mem[i] = dmem[i];
        end
        build_program(kind);
        for (int i = 0; i < 16; i++) begin
            m_regs[i] = '0;
        end
        m_pc = '0;
        m_halted = 1'b0;

        @(posedge reset_n);
        #1 reset = 1'b1;
        // Store word at the reset vector while reset is held
        first_word = imem[0];
        imem[0] = make_insn(2'b10, 1'b0, 4'd0, 4'd0, 4'd0, OP_OR, 12'd0);
        repeat (4) begin
            @(negedge reset_n);
            check(!mem_en && !mem_we, "memory strobe during reset");
            @(posedge reset_n);
        end
        #1 reset = 1'b0;
        imem[0] = first_word;
        @(negedge reset_n);
        check(insn_addr == '0 && !halt && !mem_en && !mem_we, "state after reset");

        cycles = 0;
        while (!m_halted && cycles < 1000) begin
            check(!halt, "core halted early");
            check(insn_addr == m_pc,
                  $sformatf("fetch address %0h, expected %0h", insn_addr, m_pc));
            model_step(fetch_word(m_pc));
            check(mem_en == m_en && mem_we == m_we, "memory strobes differ from model");
            if (m_we) begin
                check(mem_addr == m_addr && mem_wdata == m_wdata,
                      $sformatf("store [%0h]=%0h, expected [%0h]=%0h",
                                mem_addr, mem_wdata, m_addr, m_wdata));
                if (mem_addr < DMEM_SIZE) begin
                    dmem[mem_addr[7:0]] = mem_wdata;
                end
            end
            @(negedge reset_n);
            cycles++;
        end
        cycles = 0;
        while (!halt && cycles < 20) begin
            @(negedge reset_n);
            cycles++;
        end
        if (!halt || !m_halted) begin
            $display("timeout: %s never reached halt", name);
            $display("Test failed");
            $finish;
        end
        // An executable store now sits where the core stopped
        @(posedge reset_n);
        #1 imem[m_pc[7:0]] = make_insn(2'b10, 1'b0, 4'd1, 4'd0, 4'd0, OP_OR, 12'd0);
        repeat (10) begin
            @(negedge reset_n);
            check(halt && insn_addr == m_pc && !mem_en && !mem_we, "activity while halted");
        end

        if (errors == 0) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("%s: %s, %0d errors", name, (errors == 0) ? "pass" : "FAIL", errors);
    endtask

    initial begin
        void'($urandom(32'h4aa8_2a64));
        reset = 1'b1;
        n_pass = 0;
        n_fail = 0;
        run_test("reset", 1);
        run_test("alu", 2);
        run_test("load_store", 3);
        run_test("control_flow", 4);
        run_test("register_zero", 5);
        run_test("halt", 6);
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
